// File: src/fpu_norm_config.svh
// ----------------------------------------
// width settings for the single-precision
// normalizer; include wherever a width is needed
// ----------------------------------------
`ifndef FPU_NORM_CONFIG_SVH
`define FPU_NORM_CONFIG_SVH

// exponent incl. overflow bit
`define FPU_EXP_W 9
// 24x24 product
`define FPU_MAN_IN_W 48
// stored fraction
`define FPU_FRAC_W 23
// integer operand, upper shift part
`define FPU_INT_W 32
// one-hot number class
`define FPU_CLASS_W 10
// nx, uf, of, dz, nv
`define FPU_FLAG_W 5

`endif

// File: src/fpu_norm_pkg.sv
// ----------------------------------------
// types, FSM states and bit positions shared
// by the normalizer modules
// ----------------------------------------
`include "fpu_norm_config.svh"

package fpu_norm_pkg;

    typedef logic [`FPU_EXP_W-1:0]    exp_t;     // biased exponent / counter
    typedef logic [`FPU_MAN_IN_W-1:0] man_in_t;  // product mantissa
    typedef logic [`FPU_FRAC_W-1:0]   frac_t;
    typedef logic [`FPU_INT_W-1:0]    upper_t;   // integer part of shift reg
    typedef logic [`FPU_CLASS_W-1:0]  fclass_t;
    typedef logic [`FPU_FLAG_W-1:0]   fflags_t;
    typedef logic [2:0]               rmode_t;
    // sign + 8-bit exponent + fraction
    typedef logic [`FPU_EXP_W+`FPU_FRAC_W-1:0] fword_t;

    typedef enum logic [2:0] {
        st_idle, st_prepare_i2f, st_check_i2f, st_prepare_norm,
        st_prepare_shift, st_normalize, st_round, st_finalize
    } norm_state_e;

    // class bits --------------------------
    localparam int CLS_NEG_INF    = 0;
    localparam int CLS_NEG_NORM   = 1;
    localparam int CLS_NEG_DENORM = 2;
    localparam int CLS_NEG_ZERO   = 3;
    localparam int CLS_POS_ZERO   = 4;
    localparam int CLS_POS_DENORM = 5;
    localparam int CLS_POS_NORM   = 6;
    localparam int CLS_POS_INF    = 7;
    localparam int CLS_SNAN       = 8;
    localparam int CLS_QNAN       = 9;

    // flag bits ---------------------------
    localparam int FLG_NX = 0;
    localparam int FLG_UF = 1;
    localparam int FLG_OF = 2;
    localparam int FLG_DZ = 3;
    localparam int FLG_NV = 4;

    localparam fword_t QNAN_WORD = 32'h7fc0_0000;  // canonical quiet nan

endpackage

// File: src/fpu_norm_ctrl.sv
`timescale 1ns/100ps
// ----------------------------------------
// normalizer control FSM: sequences load,
// shift and round, tracks the exponent and
// its wrap in both directions
// ----------------------------------------
module fpu_norm_ctrl (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic                  start_i,       // only seen in idle
    input  logic                  funct_i,       // 0 norm+round, 1 int-to-float
    input  logic                  sign_i,
    input  fpu_norm_pkg::exp_t    exponent_i,
    input  fpu_norm_pkg::fclass_t class_i,
    input  fpu_norm_pkg::fflags_t flags_i,
    input  logic                  norm_done_i,   // hidden one in place
    input  logic                  zero_i,        // upper part all zero
    input  logic                  round_en_i,
    output logic                  load_i2f_o,
    output logic                  load_norm_o,
    output logic                  set_dir_o,
    output logic                  shift_en_o,
    output logic                  shift_left_o,  // counting direction
    output logic                  load_round_o,
    output logic                  sign_o,
    output fpu_norm_pkg::exp_t    cnt_o,
    output logic                  cnt_of_o,      // 255 -> 256
    output logic                  cnt_uf_o,      // 0 -> -1
    output fpu_norm_pkg::fclass_t class_o,
    output fpu_norm_pkg::fflags_t flags_o,
    output logic                  rounded_o,     // sticky over both passes
    output logic                  finalize_o
);
    import fpu_norm_pkg::*;

    // integer sits with its binary point after bit 0 of the upper part
    localparam exp_t I2F_EXP = 9'd127;

    norm_state_e state_q;
    logic        norm_r_q;  // second normalization pass
    logic        special;   // skip straight to finalize
    logic        stop;

    assign special = class_o[CLS_SNAN] | class_o[CLS_QNAN] |
                     class_o[CLS_NEG_INF] | class_o[CLS_POS_INF] |
                     class_o[CLS_NEG_ZERO] | class_o[CLS_POS_ZERO] |
                     class_o[CLS_NEG_DENORM] | class_o[CLS_POS_DENORM] |
                     flags_o[FLG_NV] | flags_o[FLG_OF] | flags_o[FLG_UF];
    assign stop    = norm_done_i | cnt_of_o | cnt_uf_o;

    // strobes to the shifter
    assign load_i2f_o   = (state_q == st_prepare_i2f);
    assign load_norm_o  = (state_q == st_prepare_norm);
    assign set_dir_o    = (state_q == st_prepare_shift);
    assign shift_en_o   = (state_q == st_normalize) & ~stop;
    assign load_round_o = (state_q == st_round);
    assign finalize_o   = (state_q == st_finalize);

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q      <= st_idle;
            norm_r_q     <= 1'b0;
            shift_left_o <= 1'b0;
            sign_o       <= 1'b0;
            cnt_o        <= '0;
            cnt_of_o     <= 1'b0;
            cnt_uf_o     <= 1'b0;
            class_o      <= '0;
            flags_o      <= '0;
            rounded_o    <= 1'b0;
        end else begin
            case (state_q)
                st_idle: begin
                    norm_r_q  <= 1'b0;
                    rounded_o <= 1'b0;
                    cnt_of_o  <= 1'b0;
                    cnt_uf_o  <= 1'b0;
                    if (start_i) begin
                        sign_o  <= sign_i;
                        cnt_o   <= funct_i ? I2F_EXP : exponent_i;
                        class_o <= funct_i ? '0 : class_i;  // class set later for i2f
                        flags_o <= flags_i;
                        state_q <= funct_i ? st_prepare_i2f : st_prepare_norm;
                    end
                end
                st_prepare_i2f: begin
                    shift_left_o <= 1'b0;  // integer only shifts right
                    state_q      <= st_check_i2f;
                end
                st_check_i2f: begin
                    if (zero_i) begin
                        class_o[CLS_POS_ZERO] <= 1'b1;  // int zero gives +0
                        state_q               <= st_finalize;
                    end else begin
                        state_q <= st_normalize;
                    end
                end
                st_prepare_norm: state_q <= st_prepare_shift;
                st_prepare_shift: begin
                    shift_left_o <= zero_i;  // below 1.0 -> shift left
                    state_q      <= (special && !norm_r_q) ? st_finalize : st_normalize;
                end
                st_normalize: begin
                    if (stop) begin
                        norm_r_q <= 1'b1;
                        state_q  <= norm_r_q ? st_finalize : st_round;
                    end else if (shift_left_o) begin
                        cnt_o <= cnt_o - 1'b1;
                        if (cnt_o == '0)
                            cnt_uf_o <= 1'b1;
                    end else begin
                        cnt_o <= cnt_o + 1'b1;
                        if (cnt_o == exp_t'(255))
                            cnt_of_o <= 1'b1;
                    end
                end
                st_round: begin
                    rounded_o <= rounded_o | round_en_i;
                    state_q   <= st_prepare_shift;  // carry may need one more shift
                end
                st_finalize: state_q <= st_idle;
                default:     state_q <= st_idle;
            endcase
        end
    end

    a_no_shift_idle: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (state_q == st_idle) |-> !shift_en_o);

endmodule

// File: src/fpu_norm_shifter.sv
`timescale 1ns/100ps
// ----------------------------------------
// 32+23+3 bit mantissa shift register with
// guard/round/sticky; driven by the control
// strobes, reports normalized and zero
// ----------------------------------------
`include "fpu_norm_config.svh"

module fpu_norm_shifter (
    input  logic                      clk_i,
    input  logic                      rstn_i,
    input  logic                      load_i2f_i,
    input  logic                      load_norm_i,
    input  logic                      set_dir_i,
    input  logic                      shift_en_i,
    input  logic                      shift_left_i,  // ctrl's counting direction
    input  logic                      load_round_i,
    input  fpu_norm_pkg::man_in_t     mantissa_i,    // stable until done
    input  fpu_norm_pkg::upper_t      integer_i,
    input  logic [`FPU_FRAC_W+1:0]    rounded_i,     // carry + hidden + fraction
    output logic                      norm_done_o,
    output logic                      zero_o,
    output logic                      lsb_o,
    output logic                      guard_o,
    output logic                      round_o,
    output logic                      sticky_o,
    output logic                      hidden_o,
    output fpu_norm_pkg::frac_t       frac_o
);
    import fpu_norm_pkg::*;

    upper_t upper_q;   // integer part, hidden one ends in bit 0
    frac_t  lower_q;   // fraction part
    logic   guard_q;
    logic   round_q;
    logic   sticky_q;
    logic   dir_q;     // 1 = shift left

    // direction ----------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i)
            dir_q <= 1'b0;
        else if (load_i2f_i)
            dir_q <= 1'b0;
        else if (set_dir_i)
            dir_q <= zero_o;  // value below 1.0
    end

    // datapath -----------------------------
    always_ff @(posedge clk_i) begin
        if (load_i2f_i) begin
            upper_q  <= integer_i;
            lower_q  <= '0;
            guard_q  <= 1'b0;
            round_q  <= 1'b0;
            sticky_q <= 1'b0;
        end else if (load_norm_i) begin
            upper_q  <= upper_t'(mantissa_i[47:46]);  // point after bit 46
            lower_q  <= mantissa_i[45:23];
            guard_q  <= mantissa_i[22];
            round_q  <= mantissa_i[21];
            sticky_q <= |mantissa_i[20:0];
        end else if (load_round_i) begin
            upper_q  <= upper_t'(rounded_i[`FPU_FRAC_W+1:`FPU_FRAC_W]);
            lower_q  <= rounded_i[`FPU_FRAC_W-1:0];
            guard_q  <= 1'b0;
            round_q  <= 1'b0;
            sticky_q <= 1'b0;
        end else if (shift_en_i) begin
            if (dir_q) begin
                {upper_q, lower_q, guard_q, round_q} <=
                    {upper_q[$bits(upper_q)-2:0], lower_q, guard_q, round_q, sticky_q};
            end else begin
                {upper_q, lower_q, guard_q, round_q} <= {1'b0, upper_q, lower_q, guard_q};
                sticky_q <= sticky_q | round_q;  // collect bits falling off
            end
        end
    end

    assign norm_done_o = (upper_q[$bits(upper_q)-1:1] == '0) & upper_q[0];
    assign zero_o      = (upper_q == '0);
    assign hidden_o    = upper_q[0];
    assign frac_o      = lower_q;
    assign lsb_o       = lower_q[0];
    assign guard_o     = guard_q;
    assign round_o     = round_q;
    assign sticky_o    = sticky_q;

    a_sticky_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (shift_en_i && !dir_q && sticky_q) |=> sticky_q);

    // exponent counting in ctrl must follow the actual shift
    a_dir_match: assert property (@(posedge clk_i) disable iff (!rstn_i)
        shift_en_i |-> (dir_q == shift_left_i));

endmodule

// File: src/fpu_round_unit.sv
`timescale 1ns/100ps
// ----------------------------------------
// rounding decision for the five IEEE modes
// and the 25-bit significand incrementer
// ----------------------------------------
`include "fpu_norm_config.svh"

module fpu_round_unit (
    input  fpu_norm_pkg::rmode_t      rmode_i,
    input  logic                      sign_i,
    input  logic                      lsb_i,
    input  logic                      guard_i,
    input  logic                      round_i,
    input  logic                      sticky_i,
    input  logic                      hidden_i,
    input  fpu_norm_pkg::frac_t       frac_i,
    output logic                      round_en_o,
    output logic [`FPU_FRAC_W+1:0]    rounded_o   // bit 24 catches the carry
);
    logic inexact;  // anything beyond the lsb

    assign inexact = guard_i | round_i | sticky_i;

    always_comb begin
        case (rmode_i)
            3'b000:  round_en_o = guard_i & (round_i | sticky_i | lsb_i);  // ties to even
            3'b001:  round_en_o = 1'b0;                                    // toward zero
            3'b010:  round_en_o = sign_i & inexact;                        // toward -inf
            3'b011:  round_en_o = ~sign_i & inexact;                       // toward +inf
            3'b100:  round_en_o = guard_i;                                 // ties to max mag
            default: round_en_o = 1'b0;                                    // truncate
        endcase
    end

    assign rounded_o = {1'b0, hidden_i, frac_i} + {{(`FPU_FRAC_W+1){1'b0}}, round_en_o};

endmodule

// File: src/fpu_norm_result.sv
`timescale 1ns/100ps
// ----------------------------------------
// exponent range checks, special-value
// selection and the registered result/flags;
// done follows the finalize pulse by one cycle
// ----------------------------------------
module fpu_norm_result (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic                  finalize_i,
    input  logic                  sign_i,
    input  fpu_norm_pkg::exp_t    cnt_i,       // final biased exponent
    input  logic                  cnt_of_i,
    input  logic                  cnt_uf_i,
    input  logic                  zero_i,
    input  fpu_norm_pkg::fclass_t class_i,
    input  fpu_norm_pkg::fflags_t flags_i,
    input  logic                  rounded_i,
    input  fpu_norm_pkg::frac_t   frac_i,
    output fpu_norm_pkg::fword_t  result_o,
    output fpu_norm_pkg::fflags_t flags_o,
    output logic                  done_o
);
    import fpu_norm_pkg::*;

    logic    is_nan, is_inf, is_zero, is_denorm;
    logic    uf, of;
    fflags_t flags_nxt;
    fword_t  result_nxt;

    assign is_nan    = class_i[CLS_SNAN] | class_i[CLS_QNAN];
    assign is_inf    = class_i[CLS_NEG_INF] | class_i[CLS_POS_INF];
    assign is_zero   = class_i[CLS_NEG_ZERO] | class_i[CLS_POS_ZERO];
    assign is_denorm = class_i[CLS_NEG_DENORM] | class_i[CLS_POS_DENORM];

    // range checks only for values that went through the shifter
    always_comb begin
        uf = 1'b0;
        of = 1'b0;
        if (!(is_nan | is_inf | is_zero | is_denorm)) begin
            if (cnt_uf_i)
                uf = 1'b1;
            else if (cnt_of_i)
                of = 1'b1;
            else if (cnt_i[7:0] == 8'h00)
                uf = 1'b1;  // would be subnormal, flushed
            else if (cnt_i[7:0] == 8'hff)
                of = 1'b1;
        end
    end

    always_comb begin
        flags_nxt         = flags_i;
        flags_nxt[FLG_UF] = flags_i[FLG_UF] | uf;
        flags_nxt[FLG_OF] = flags_i[FLG_OF] | of;
        flags_nxt[FLG_NV] = flags_i[FLG_NV] | class_i[CLS_SNAN];
        flags_nxt[FLG_NX] = flags_i[FLG_NX] | rounded_i;
    end

    // priority matters here
    always_comb begin
        if (is_nan)
            result_nxt = QNAN_WORD;
        else if (is_inf || flags_nxt[FLG_OF])
            result_nxt = {sign_i, 8'hff, 23'b0};           // signed infinity
        else if (is_zero)
            result_nxt = {class_i[CLS_NEG_ZERO], 31'b0};
        else if (flags_nxt[FLG_UF] || zero_i || is_denorm)
            result_nxt = {sign_i, 31'b0};                  // flush to zero
        else
            result_nxt = {sign_i, cnt_i[7:0], frac_i};
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            done_o   <= 1'b0;
            result_o <= '0;
            flags_o  <= '0;
        end else begin
            done_o <= finalize_i;  // one-cycle pulse
            if (finalize_i) begin
                result_o <= result_nxt;
                flags_o  <= flags_nxt;
            end
        end
    end

endmodule

// File: src/fpu_normalizer.sv
`timescale 1ns/100ps
// ----------------------------------------
// single-precision normalizer and rounding
// stage; start/done handshake, one op at a time
// ----------------------------------------
`include "fpu_norm_config.svh"

module fpu_normalizer (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic                  start_i,
    input  fpu_norm_pkg::rmode_t  rmode_i,
    input  logic                  funct_i,     // 1 = int-to-float
    input  logic                  sign_i,
    input  fpu_norm_pkg::exp_t    exponent_i,
    input  fpu_norm_pkg::man_in_t mantissa_i,
    input  fpu_norm_pkg::upper_t  integer_i,
    input  fpu_norm_pkg::fclass_t class_i,
    input  fpu_norm_pkg::fflags_t flags_i,
    output fpu_norm_pkg::fword_t  result_o,
    output fpu_norm_pkg::fflags_t flags_o,
    output logic                  done_o
);
    import fpu_norm_pkg::*;

    // ctrl -> shifter
    logic load_i2f, load_norm, set_dir, shift_en, shift_left, load_round;
    // ctrl -> result
    logic    sign, cnt_of, cnt_uf, rounded, finalize;
    exp_t    cnt;
    fclass_t cls;
    fflags_t flags;
    // shifter -> round/result
    logic  norm_done, zero, lsb, guard, rnd, sticky, hidden;
    frac_t frac;
    // round unit
    logic                   round_en;
    logic [`FPU_FRAC_W+1:0] rounded_man;

    fpu_norm_ctrl u_ctrl (
        .clk_i, .rstn_i, .start_i, .funct_i, .sign_i, .exponent_i, .class_i, .flags_i,
        .norm_done_i(norm_done), .zero_i(zero), .round_en_i(round_en),
        .load_i2f_o(load_i2f), .load_norm_o(load_norm), .set_dir_o(set_dir),
        .shift_en_o(shift_en), .shift_left_o(shift_left), .load_round_o(load_round),
        .sign_o(sign), .cnt_o(cnt), .cnt_of_o(cnt_of), .cnt_uf_o(cnt_uf),
        .class_o(cls), .flags_o(flags), .rounded_o(rounded), .finalize_o(finalize)
    );

    fpu_norm_shifter u_shift (
        .clk_i, .rstn_i, .load_i2f_i(load_i2f), .load_norm_i(load_norm),
        .set_dir_i(set_dir), .shift_en_i(shift_en), .shift_left_i(shift_left),
        .load_round_i(load_round), .mantissa_i, .integer_i, .rounded_i(rounded_man),
        .norm_done_o(norm_done), .zero_o(zero), .lsb_o(lsb), .guard_o(guard),
        .round_o(rnd), .sticky_o(sticky), .hidden_o(hidden), .frac_o(frac)
    );

    fpu_round_unit u_round (
        .rmode_i, .sign_i(sign), .lsb_i(lsb), .guard_i(guard), .round_i(rnd),
        .sticky_i(sticky), .hidden_i(hidden), .frac_i(frac),
        .round_en_o(round_en), .rounded_o(rounded_man)
    );

    fpu_norm_result u_result (
        .clk_i, .rstn_i, .finalize_i(finalize), .sign_i(sign), .cnt_i(cnt),
        .cnt_of_i(cnt_of), .cnt_uf_i(cnt_uf), .zero_i(zero), .class_i(cls),
        .flags_i(flags), .rounded_i(rounded), .frac_i(frac),
        .result_o, .flags_o, .done_o
    );

endmodule

// File: verif/tb_fpu_normalizer.sv
`timescale 1ns/100ps
// ----------------------------------------
// testbench for the normalizer: random int-to-float
// and float ops against a reference model, plus
// special classes, exponent edges and busy starts
// ----------------------------------------
`include "fpu_norm_config.svh"

module tb_fpu_normalizer;
    import fpu_norm_pkg::*;

    localparam int N_I2F   = 40;   // per rounding mode
    localparam int N_ZERO  = 4;
    localparam int N_FLT   = 300;
    localparam int N_CARRY = 24;
    localparam int N_EDGE  = 80;
    localparam int N_SPEC  = 8;    // ten classes minus the two normal ones
    localparam int N_BUSY  = 8;
    localparam int BUSY_WINDOW = 60;  // longer than the slowest op
    localparam int N_OPS = 5 * N_I2F + N_ZERO + N_FLT + N_CARRY + N_EDGE + N_SPEC + N_BUSY;
    localparam int CYCLE_LIMIT = 200 * N_OPS;

    logic    clk_i, rstn_i, start_i, funct_i, sign_i, done_o;
    rmode_t  rmode_i;
    exp_t    exponent_i;
    man_in_t mantissa_i;
    upper_t  integer_i;
    fclass_t class_i;
    fflags_t flags_i, flags_o;
    fword_t  result_o;

    integer seed = 32'h80356cc9;
    int     checks = 0;
    int     errors = 0;
    int     test_errors = 0;
    int     done_pulses = 0;
    int     cycle_cnt = 0;

    fpu_normalizer u_dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;  // 4 ns period
    end

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, the run did not finish", cycle_cnt);
            $display("Some tests failed");
            $finish;
        end
    end

    always @(negedge clk_i)
        if (done_o)
            done_pulses <= done_pulses + 1;  // every pulse, accepted or not

    // helpers -------------------------------
    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // product of two significands in [1,2), so bits 47:46 never both zero
    function automatic man_in_t rand_product();
        logic [23:0] a, b;
        a = {1'b1, 23'($random(seed))};
        b = {1'b1, 23'($random(seed))};
        return man_in_t'(a) * man_in_t'(b);
    endfunction

    // fraction all ones and guard set, most modes carry
    function automatic man_in_t carry_pattern(input logic wide);
        if (wide)
            return {2'b11, 22'h3fffff, 1'b1, 23'($random(seed))};
        return {2'b01, 23'h7fffff, 1'b1, 22'($random(seed))};
    endfunction

    function automatic fclass_t norm_class(input logic sgn);
        return fclass_t'(1) << (sgn ? CLS_NEG_NORM : CLS_POS_NORM);
    endfunction

    // reference model ----------------------
    // exact fixed point, leading one moved to bit 63, then IEEE rounding
    function automatic logic [36:0] ref_model(input logic from_int, input logic sgn,
            input exp_t exp_in, input man_in_t man, input upper_t ival, input rmode_t rm);
        logic [63:0] val;
        logic [63:0] aligned;
        logic [24:0] sig;
        logic        grd, rnd, stk, up;
        fflags_t     fl;
        fword_t      word;
        int          msb;
        int          ex;
        val = from_int ? 64'(ival) : 64'(man);
        ex  = from_int ? 158 - 31 : int'(exp_in) - 46;  // exponent of bit 0
        msb = -1;
        for (int i = 0; i < 64; i++)
            if (val[i])
                msb = i;
        if (msb < 0)
            return '0;                  // integer zero gives +0
        aligned = val << (63 - msb);
        ex      = ex + msb;
        grd     = aligned[39];
        rnd     = aligned[38];
        stk     = |aligned[37:0];
        case (rm)
            3'd0:    up = grd && (rnd || stk || aligned[40]);  // nearest even
            3'd1:    up = 1'b0;
            3'd2:    up = sgn && (grd || rnd || stk);
            3'd3:    up = !sgn && (grd || rnd || stk);
            3'd4:    up = grd;                                // nearest max magnitude
            default: up = 1'b0;
        endcase
        sig = {1'b0, aligned[63:40]} + 25'(up);
        if (sig[24]) begin
            sig = sig >> 1;             // carry into next binade
            ex  = ex + 1;
        end
        fl         = '0;
        fl[FLG_NX] = up;
        if (ex <= 0) begin
            fl[FLG_UF] = 1'b1;
            word       = {sgn, 31'b0};
        end else if (ex >= 255) begin
            fl[FLG_OF] = 1'b1;
            word       = {sgn, 8'hff, 23'b0};
        end else begin
            word = {sgn, 8'(ex), sig[22:0]};
        end
        return {fl, word};
    endfunction

    // drive and check -----------------------
    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("Error at time %0t: %s = %0h, expected %0h", $time, name, got, want);
        end
    endtask

    task automatic launch(input logic f, input logic s, input exp_t e, input man_in_t m,
                          input upper_t iv, input fclass_t cls, input rmode_t rm);
        @(posedge clk_i);
        start_i    <= 1'b1;
        funct_i    <= f;
        sign_i     <= s;
        exponent_i <= e;
        mantissa_i <= m;            // held until the next launch
        integer_i  <= iv;
        class_i    <= cls;
        rmode_i    <= rm;
        @(posedge clk_i);
        start_i    <= 1'b0;         // this edge accepted the start
    endtask

    task automatic wait_for_done(output int lat);
        lat = 0;
        do begin
            @(posedge clk_i);
            lat++;
            @(negedge clk_i);
        end while (!done_o);
    endtask

    task automatic check_op(input logic f, input logic s, input exp_t e, input man_in_t m,
                            input upper_t iv, input fclass_t cls, input rmode_t rm,
                            input logic [36:0] want, input int want_lat);
        int lat;
        launch(f, s, e, m, iv, cls, rm);
        wait_for_done(lat);
        compare("result_o", result_o, want[31:0]);
        compare("flags_o", 32'(flags_o), 32'(want[36:32]));
        if (want_lat >= 0)
            compare("done_o latency", lat + 1, want_lat);  // from the edge driving start
    endtask

    task automatic end_test(input int num, input string name);
        $display("test %0d %s: %0d errors", num, name, errors - test_errors);
        test_errors = errors;
    endtask

    // test sequence -------------------------
    initial begin
        logic [36:0] want;
        man_in_t     m;
        upper_t      iv;
        exp_t        e;
        logic        s, f;
        rmode_t      rm;
        int          pulses;
        rstn_i     = 1'b0;
        start_i    = 1'b0;
        funct_i    = 1'b0;
        sign_i     = 1'b0;
        rmode_i    = '0;
        exponent_i = '0;
        mantissa_i = '0;
        integer_i  = '0;
        class_i    = '0;
        flags_i    = '0;
        repeat (8) @(posedge clk_i);
        rstn_i <= 1'b1;
        @(negedge clk_i);
        compare("done_o", 32'(done_o), 32'h0);
        compare("result_o", result_o, 32'h0);
        compare("flags_o", 32'(flags_o), 32'h0);
        end_test(0, "reset values");

        for (int md = 0; md < 5; md++) begin
            for (int n = 0; n < N_I2F; n++) begin
                iv = upper_t'($random(seed)) >> rand_below(32);  // spread magnitudes
                if (iv == '0)
                    iv = 32'd1;
                s = 1'(rand_below(2));
                check_op(1'b1, s, '0, '0, iv, '0, rmode_t'(md),
                         ref_model(1'b1, s, '0, '0, iv, rmode_t'(md)), -1);
            end
        end
        end_test(1, "int-to-float, five modes");

        for (int n = 0; n < N_ZERO; n++)
            check_op(1'b1, 1'(n), '0, '0, '0, '0, rmode_t'(n), '0, 4);
        end_test(2, "int-to-float of zero");

        for (int n = 0; n < N_FLT + N_CARRY; n++) begin
            m  = (n < N_FLT) ? rand_product() : carry_pattern(1'(n));
            e  = exp_t'(1 + rand_below(253));
            s  = 1'(rand_below(2));
            rm = rmode_t'(rand_below(5));
            check_op(1'b0, s, e, m, '0, norm_class(s), rm, ref_model(1'b0, s, e, m, '0, rm), -1);
        end
        end_test(3, "float normalize and round");

        for (int n = 0; n < N_EDGE; n++) begin
            m  = rand_below(2) ? rand_product() : carry_pattern(1'(rand_below(2)));
            e  = exp_t'(rand_below(2) ? rand_below(2) : 254 + rand_below(2));  // 0,1,254,255
            s  = 1'(rand_below(2));
            rm = rmode_t'(rand_below(5));
            check_op(1'b0, s, e, m, '0, norm_class(s), rm, ref_model(1'b0, s, e, m, '0, rm), -1);
        end
        end_test(4, "exponent edges");

        for (int k = 0; k < 10; k++) begin
            if (k == CLS_NEG_NORM || k == CLS_POS_NORM)
                continue;
            s = (k <= CLS_NEG_ZERO);    // negative classes sit at the low end
            if (k >= CLS_SNAN)
                want = {(k == CLS_SNAN) ? fflags_t'(1) << FLG_NV : fflags_t'(0), 32'h7fc0_0000};
            else if (k == CLS_NEG_INF || k == CLS_POS_INF)
                want = {5'b0, s, 8'hff, 23'b0};
            else
                want = {5'b0, s, 31'b0};  // zero and subnormal both end as signed zero
            check_op(1'b0, s, exp_t'(rand_below(255)), rand_product(), '0,
                     fclass_t'(1) << k, rmode_t'(rand_below(5)), want, 4);
        end
        end_test(5, "special classes");

        for (int n = 0; n < N_BUSY; n++) begin
            f  = 1'(n);
            m  = rand_product();
            iv = upper_t'($random(seed)) | 32'h1;
            e  = exp_t'(1 + rand_below(253));
            s  = 1'(rand_below(2));
            rm = rmode_t'(rand_below(5));
            want = ref_model(f, s, e, m, iv, rm);
            launch(f, s, e, m, iv, f ? fclass_t'(0) : norm_class(s), rm);
            pulses = done_pulses;
            @(posedge clk_i);
            start_i    <= 1'b1;         // second start while busy
            sign_i     <= ~s;
            funct_i    <= ~f;
            exponent_i <= exp_t'(rand_below(255));
            @(posedge clk_i);
            start_i    <= 1'b0;
            repeat (BUSY_WINDOW) @(posedge clk_i);
            @(negedge clk_i);
            checks++;
            if (done_pulses - pulses != 1) begin
                errors++;
                $display("done_o pulsed %0d times for one accepted start at time %0t",
                         done_pulses - pulses, $time);
            end
            compare("result_o", result_o, want[31:0]);
            compare("flags_o", 32'(flags_o), 32'(want[36:32]));
        end
        end_test(6, "start while busy");

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

// File: build.f
+incdir+src
src/fpu_norm_pkg.sv
src/fpu_norm_ctrl.sv
src/fpu_norm_shifter.sv
src/fpu_round_unit.sv
src/fpu_norm_result.sv
src/fpu_normalizer.sv
verif/tb_fpu_normalizer.sv

// File: Makefile
# Verilator build and run of the normalizer testbench

VERILATOR ?= verilator
TOP       ?= tb_fpu_normalizer
LOG       ?= sim.log
SEED_ARGS ?= +verilator+seed+1
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: help test build clean

help:
	@echo "targets:"
	@echo "  test   build with $(VERILATOR), run $(TOP), log to $(LOG), check the result"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP LOG SEED_ARGS FILELIST OBJ_DIR VFLAGS"

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

test: build
	./$(SIM_BIN) $(SEED_ARGS) | tee $(LOG)
	@grep -qx "All tests passed" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
